// ==== sdramGeomPkg.sv ====
package sdramGeomPkg;

	// Data bus
	localparam int DATA_W = 16;             // DQ width
	localparam int DQM_W  = DATA_W / 8;     // One mask lane per byte

	// Linear word address, bank over row over column
	localparam int COL_W  = 8;              // 256 words per page
	localparam int ROW_W  = 12;
	localparam int BANK_W = 2;
	localparam int ADDR_W = BANK_W + ROW_W + COL_W;

	localparam int LEN_W  = 9;              // Up to one full page
	localparam int SA_W   = 12;             // Address pins

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [LEN_W-1:0]  len_t;

endpackage

// ==== sdramCmdPkg.sv ====
package sdramCmdPkg;

	// Pin encoding {csN, rasN, casN, weN}
	typedef enum logic [3:0] {
		NOP        = 4'b0111,
		ACTIVE     = 4'b0011,
		READ       = 4'b0101,
		WRITE      = 4'b0100,
		BURST_STOP = 4'b0110,
		PRECHARGE  = 4'b0010,
		REFRESH    = 4'b0001,
		LOAD_MODE  = 4'b0000
	} sdramCmd_t;

	// Sequencer states
	typedef enum logic [3:0] {
		INIT_WAIT, INIT_PRE, INIT_REF, INIT_MODE,   // Power-up
		IDLE, ACT_WAIT, BURST, STOP, PRE_WAIT, REF_WAIT
	} seqState_t;

	typedef enum logic [1:0] {IDLE_OP, WRITE_OP, READ_OP} burstOp_t;

	// Burst length field all ones for full page, sequential, CAS field empty
	localparam logic [sdramGeomPkg::SA_W-1:0] MODE_FULL_PAGE = 'h007;
	localparam int MODE_CAS_LSB  = 4;       // CAS latency field A6..A4
	localparam int A10_ALL_BANKS = 10;      // Precharge all banks

endpackage

// ==== syncFifo.sv ====
`timescale 1ns/1ps
module syncFifo #(
	parameter int FIFO_DEPTH = 512
) (
	input  logic                            CLK,
	input  logic                            RESET_N,
	input  logic                            clear,      // Empties in one cycle
	input  logic                            push,
	input  sdramGeomPkg::data_t             pushData,
	input  logic                            pop,
	output sdramGeomPkg::data_t             headData,   // Show-ahead head word
	output logic [$clog2(FIFO_DEPTH+1)-1:0] count,
	output logic                            full,
	output logic                            empty
);
	import sdramGeomPkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	data_t            mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic             doPush;    // Push accepted
	logic             doPop;     // Pop accepted

	assign full     = (count == FIFO_DEPTH);
	assign empty    = (count == '0);
	assign doPush   = push && !full;     // Ignored when full
	assign doPop    = pop && !empty;     // Ignored when empty
	assign headData = mem[rdPtr];

	always_ff @(posedge CLK)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	// Pointers and occupancy
	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else if (clear)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= (wrPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== portArbiter.sv ====
`timescale 1ns/1ps
module portArbiter #(
	parameter int FIFO_DEPTH = 512
) (
	input  logic                            CLK,
	input  logic                            RESET_N,
	input  sdramGeomPkg::addr_t             wrBase,
	input  sdramGeomPkg::addr_t             wrMax,
	input  sdramGeomPkg::addr_t             rdBase,
	input  sdramGeomPkg::addr_t             rdMax,
	input  sdramGeomPkg::len_t              wrLength,
	input  sdramGeomPkg::len_t              rdLength,
	input  logic                            wrLoad,     // Level, reload address
	input  logic                            rdLoad,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0] wrCount,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0] rdCount,
	input  logic                            burstDone,
	output logic                            burstStart, // One-cycle pulse
	output sdramCmdPkg::burstOp_t           burstOp,
	output sdramGeomPkg::addr_t             burstAddr,
	output sdramGeomPkg::len_t              burstLen
);
	import sdramGeomPkg::*;
	import sdramCmdPkg::*;

	addr_t wrAddr;      // Running write address
	addr_t rdAddr;      // Running read address
	logic  primed;      // Low for the first cycle out of reset
	logic  pending;     // Burst issued, waiting for done
	logic  wrEligible;
	logic  rdEligible;

	// Step by length, back to base once max minus length is reached
	function automatic addr_t nextAddr(addr_t cur, addr_t base, addr_t maxAddr, len_t len);
		logic [ADDR_W:0] reach;
		logic [ADDR_W:0] limit;
		reach = {1'b0, cur} + len;
		limit = {1'b0, maxAddr} - len;
		if (reach >= limit)
			return base;
		return addr_t'(reach);
	endfunction

	// Whole burst already buffered
	assign wrEligible = primed && !wrLoad && (wrLength != '0) && (wrCount >= wrLength);
	// Room for a whole burst, so the read side never stalls
	assign rdEligible = primed && !rdLoad && (rdLength != '0)
		&& (({1'b0, rdCount} + rdLength) <= FIFO_DEPTH);

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			wrAddr     <= '0;
			rdAddr     <= '0;
			primed     <= 1'b0;
			pending    <= 1'b0;
			burstStart <= 1'b0;
			burstOp    <= IDLE_OP;
			burstAddr  <= '0;
			burstLen   <= '0;
		end
		else
		begin
			primed     <= 1'b1;
			burstStart <= 1'b0;
			if (!primed || wrLoad)                          // Base reload
				wrAddr <= wrBase;
			else if (burstDone && burstOp == WRITE_OP)
				wrAddr <= nextAddr(wrAddr, wrBase, wrMax, burstLen);
			if (!primed || rdLoad)
				rdAddr <= rdBase;
			else if (burstDone && burstOp == READ_OP)
				rdAddr <= nextAddr(rdAddr, rdBase, rdMax, burstLen);

			if (burstDone)
			begin
				pending <= 1'b0;
				burstOp <= IDLE_OP;
			end
			else if (!pending && wrEligible)                // Writes first
			begin
				pending    <= 1'b1;
				burstStart <= 1'b1;
				burstOp    <= WRITE_OP;
				burstAddr  <= wrAddr;
				burstLen   <= wrLength;
			end
			else if (!pending && rdEligible)
			begin
				pending    <= 1'b1;
				burstStart <= 1'b1;
				burstOp    <= READ_OP;
				burstAddr  <= rdAddr;
				burstLen   <= rdLength;
			end
		end
	end

endmodule

// ==== burstSequencer.sv ====
`timescale 1ns/1ps
module burstSequencer #(
	parameter int CAS_LATENCY    = 3,
	parameter int T_RCD          = 2,
	parameter int T_RP           = 2,
	parameter int T_RFC          = 7,
	parameter int REFRESH_PERIOD = 390,
	parameter int INIT_WAIT      = 200
) (
	input  logic                            CLK,
	input  logic                            RESET_N,
	input  logic                            burstStart,
	input  sdramCmdPkg::burstOp_t           burstOp,
	input  sdramGeomPkg::addr_t             burstAddr,
	input  sdramGeomPkg::len_t              burstLen,
	output logic                            burstDone,  // One-cycle pulse
	output sdramCmdPkg::sdramCmd_t          cmd,
	output logic [sdramGeomPkg::SA_W-1:0]   sdramAddr,
	output logic [sdramGeomPkg::BANK_W-1:0] bank,
	output logic                            cke,
	output logic [sdramGeomPkg::DQM_W-1:0]  dqm,
	output logic                            wrPop,
	output logic                            dataOe,
	output logic                            readWindow  // Aligned with READ on pins
);
	import sdramGeomPkg::*;
	import sdramCmdPkg::*;

	localparam int T_MRD   = 2;                         // Mode load to next command
	localparam int CNT_MAX = (INIT_WAIT > 256) ? INIT_WAIT : 256;
	localparam int CNT_W   = $clog2(CNT_MAX + 1);
	localparam int REF_W   = $clog2(REFRESH_PERIOD + 1);
	localparam logic [SA_W-1:0] MODE_WORD = MODE_FULL_PAGE | (SA_W'(CAS_LATENCY) << MODE_CAS_LSB);
	localparam logic [SA_W-1:0] PRE_ALL   = SA_W'(1) << A10_ALL_BANKS;

	seqState_t        state;
	logic [CNT_W-1:0] cnt;          // Cycles spent in the current state
	logic [REF_W-1:0] refCnt;
	logic             refReq;       // Refresh owed
	logic             startHeld;    // Start taken, burst not yet begun
	logic             initRefLeft;  // Second power-up refresh owed
	burstOp_t         curOp;
	addr_t            curAddr;
	len_t             curLen;
	logic             isRead;

	assign isRead = (curOp == READ_OP);
	assign cke    = 1'b1;                               // No power-down
	assign wrPop  = (state == BURST) && (curOp == WRITE_OP);
	assign dataOe = (state == BURST) && !isRead;

	// ========================================
	// Refresh timer
	// ========================================
	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			refCnt <= '0;
			refReq <= 1'b0;
		end
		else
		begin
			if (state == IDLE && refReq)
				refReq <= 1'b0;                             // Served this cycle
			if (refCnt == REF_W'(REFRESH_PERIOD - 1))
			begin
				refCnt <= '0;
				refReq <= 1'b1;
			end
			else
				refCnt <= refCnt + 1'b1;
		end
	end

	// Burst payload, latched on start
	always_ff @(posedge CLK)
	begin
		if (burstStart)
		begin
			curAddr <= burstAddr;
			curLen  <= burstLen;
		end
	end

	// ========================================
	// Command FSM, all pin outputs registered
	// ========================================
	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			state       <= sdramCmdPkg::INIT_WAIT;       // The state, not the delay
			cnt         <= '0;
			startHeld   <= 1'b0;
			initRefLeft <= 1'b1;
			curOp       <= IDLE_OP;
			cmd         <= NOP;
			sdramAddr   <= '0;
			bank        <= '0;
			dqm         <= '1;
			burstDone   <= 1'b0;
			readWindow  <= 1'b0;
		end
		else
		begin
			cmd        <= NOP;
			dqm        <= '1;
			burstDone  <= 1'b0;
			readWindow <= 1'b0;
			cnt        <= cnt + 1'b1;
			if (burstStart)
			begin
				startHeld <= 1'b1;                          // Held across a refresh
				curOp     <= burstOp;
			end
			case (state)
			sdramCmdPkg::INIT_WAIT:
				if (cnt == CNT_W'(INIT_WAIT - 1))
				begin
					state <= INIT_PRE;
					cnt   <= '0;
				end
			INIT_PRE:
			begin
				if (cnt == '0)
				begin
					cmd       <= PRECHARGE;
					sdramAddr <= PRE_ALL;
				end
				if (cnt == CNT_W'(T_RP))
				begin
					state <= INIT_REF;
					cnt   <= '0;
				end
			end
			INIT_REF:
			begin
				if (cnt == '0)
					cmd <= REFRESH;
				if (cnt == CNT_W'(T_RFC))
				begin
					cnt         <= '0;
					initRefLeft <= 1'b0;
					if (!initRefLeft)
						state <= INIT_MODE;                     // Both refreshes done
				end
			end
			INIT_MODE:
			begin
				if (cnt == '0)
				begin
					cmd       <= LOAD_MODE;
					sdramAddr <= MODE_WORD;
					bank      <= '0;
				end
				if (cnt == CNT_W'(T_MRD))
					state <= IDLE;
			end
			IDLE:
			begin
				cnt <= '0;
				if (refReq)                                 // Refresh before any burst
				begin
					cmd   <= REFRESH;
					state <= REF_WAIT;
				end
				else if (startHeld)
				begin
					cmd       <= ACTIVE;
					sdramAddr <= curAddr[COL_W +: ROW_W];
					bank      <= curAddr[COL_W + ROW_W +: BANK_W];
					startHeld <= 1'b0;
					state     <= ACT_WAIT;
				end
			end
			REF_WAIT:
				if (cnt == CNT_W'(T_RFC - 1))
					state <= IDLE;
			ACT_WAIT:
				if (cnt == CNT_W'(T_RCD - 1))
				begin
					state <= BURST;
					cnt   <= '0;
				end
			BURST:
			begin
				dqm        <= '0;                           // Data cycles unmasked
				readWindow <= isRead;
				if (cnt == '0)
				begin
					cmd       <= isRead ? READ : WRITE;
					sdramAddr <= SA_W'(curAddr[COL_W-1:0]);  // A10 low, no auto precharge
				end
				if (cnt == CNT_W'(curLen - 1'b1))
				begin
					state <= STOP;
					cnt   <= '0;
				end
			end
			STOP:
			begin
				dqm <= {DQM_W{!isRead}};                    // Read data still trailing
				if (cnt == '0)
					cmd <= BURST_STOP;
				else
				begin
					cmd       <= PRECHARGE;
					sdramAddr <= PRE_ALL;
					state     <= PRE_WAIT;
					cnt       <= '0;
				end
			end
			PRE_WAIT:
			begin
				dqm <= {DQM_W{!isRead}};
				if (cnt == CNT_W'(T_RP - 1))
				begin
					state     <= IDLE;
					burstDone <= 1'b1;
					curOp     <= IDLE_OP;
				end
			end
			default:
				state <= IDLE;
			endcase
		end
	end

endmodule

// ==== sdramDataPath.sv ====
`timescale 1ns/1ps
module sdramDataPath #(
	parameter int CAS_LATENCY = 3
) (
	input  logic                              CLK,
	input  logic                              RESET_N,
	input  sdramGeomPkg::data_t               wrWord,     // Write FIFO head
	input  logic                              dataOe,
	input  logic                              readWindow,
	inout  wire [sdramGeomPkg::DATA_W-1:0]    dq,
	output logic                              rdFifoPush,
	output sdramGeomPkg::data_t               rdWord      // Captured DQ
);
	import sdramGeomPkg::*;

	data_t                wrReg;       // Lines up with the registered WRITE
	logic                 oeReg;
	logic [CAS_LATENCY:0] windowPipe;  // CAS latency plus capture stage

	always_ff @(posedge CLK)
	begin
		wrReg  <= wrWord;
		rdWord <= dq;                  // Sampled every cycle
	end

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			oeReg      <= 1'b0;
			windowPipe <= '0;
		end
		else
		begin
			oeReg      <= dataOe;
			windowPipe <= {windowPipe[CAS_LATENCY-1:0], readWindow};
		end
	end

	assign dq         = oeReg ? wrReg : 'z;  // Released outside write bursts
	assign rdFifoPush = windowPipe[CAS_LATENCY];

endmodule

// ==== sdramCtrl.sv ====
`timescale 1ns/1ps
module sdramCtrl #(
	parameter int CAS_LATENCY    = 3,
	parameter int T_RCD          = 2,
	parameter int T_RP           = 2,
	parameter int T_RFC          = 7,
	parameter int REFRESH_PERIOD = 390,
	parameter int INIT_WAIT      = 200,
	parameter int FIFO_DEPTH     = 512
) (
	input  logic                            CLK,
	input  logic                            RESET_N,
	// Write port
	input  sdramGeomPkg::data_t             wrData,
	input  logic                            wrPush,
	output logic                            wrFull,
	input  logic                            wrLoad,
	input  sdramGeomPkg::addr_t             wrBase,
	input  sdramGeomPkg::addr_t             wrMax,
	input  sdramGeomPkg::len_t              wrLength,
	// Read port
	input  logic                            rdPop,
	output sdramGeomPkg::data_t             rdData,
	output logic                            rdEmpty,
	input  logic                            rdLoad,
	input  sdramGeomPkg::addr_t             rdBase,
	input  sdramGeomPkg::addr_t             rdMax,
	input  sdramGeomPkg::len_t              rdLength,
	// SDRAM pins
	output logic [sdramGeomPkg::SA_W-1:0]   sdramAddr,
	output logic [sdramGeomPkg::BANK_W-1:0] bank,
	output logic                            csN,
	output logic                            cke,
	output logic                            rasN,
	output logic                            casN,
	output logic                            weN,
	output logic [sdramGeomPkg::DQM_W-1:0]  dqm,
	inout  wire [sdramGeomPkg::DATA_W-1:0]  dq
);
	import sdramGeomPkg::*;
	import sdramCmdPkg::*;

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [CNT_W-1:0] wrCount;
	logic [CNT_W-1:0] rdCount;
	data_t            wrHead;       // Next word to write
	data_t            rdWord;       // Captured read word
	logic             wrPop;
	logic             rdFifoPush;
	logic             burstStart;
	logic             burstDone;
	logic             dataOe;
	logic             readWindow;
	burstOp_t         burstOp;
	addr_t            burstAddr;
	len_t             burstLen;
	sdramCmd_t        cmd;

	assign {csN, rasN, casN, weN} = cmd;   // Command strobes

	// ========================================
	// Port FIFOs
	// ========================================
	syncFifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_wrFifo (
		.CLK(CLK), .RESET_N(RESET_N), .clear(wrLoad),
		.push(wrPush), .pushData(wrData), .pop(wrPop), .headData(wrHead),
		.count(wrCount), .full(wrFull), .empty()
	);

	syncFifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rdFifo (
		.CLK(CLK), .RESET_N(RESET_N), .clear(rdLoad),
		.push(rdFifoPush), .pushData(rdWord), .pop(rdPop), .headData(rdData),
		.count(rdCount), .full(), .empty(rdEmpty)
	);

	portArbiter #(.FIFO_DEPTH(FIFO_DEPTH)) u_arbiter (
		.CLK(CLK), .RESET_N(RESET_N),
		.wrBase(wrBase), .wrMax(wrMax), .rdBase(rdBase), .rdMax(rdMax),
		.wrLength(wrLength), .rdLength(rdLength), .wrLoad(wrLoad), .rdLoad(rdLoad),
		.wrCount(wrCount), .rdCount(rdCount), .burstDone(burstDone),
		.burstStart(burstStart), .burstOp(burstOp), .burstAddr(burstAddr), .burstLen(burstLen)
	);

	// ========================================
	// Command and data side
	// ========================================
	burstSequencer #(
		.CAS_LATENCY(CAS_LATENCY), .T_RCD(T_RCD), .T_RP(T_RP), .T_RFC(T_RFC),
		.REFRESH_PERIOD(REFRESH_PERIOD), .INIT_WAIT(INIT_WAIT)
	) u_sequencer (
		.CLK(CLK), .RESET_N(RESET_N), .burstStart(burstStart), .burstOp(burstOp),
		.burstAddr(burstAddr), .burstLen(burstLen), .burstDone(burstDone), .cmd(cmd),
		.sdramAddr(sdramAddr), .bank(bank), .cke(cke), .dqm(dqm),
		.wrPop(wrPop), .dataOe(dataOe), .readWindow(readWindow)
	);

	sdramDataPath #(.CAS_LATENCY(CAS_LATENCY)) u_dataPath (
		.CLK(CLK), .RESET_N(RESET_N), .wrWord(wrHead), .dataOe(dataOe),
		.readWindow(readWindow), .dq(dq), .rdFifoPush(rdFifoPush), .rdWord(rdWord)
	);

endmodule

// ==== sdramModel.sv ====
`timescale 1ns/1ps
module sdramModel #(
	parameter int CAS_LATENCY = 3
) (
	input  logic                            CLK,
	input  logic                            csN,
	input  logic                            rasN,
	input  logic                            casN,
	input  logic                            weN,
	input  logic [sdramGeomPkg::BANK_W-1:0] bank,
	input  logic [sdramGeomPkg::SA_W-1:0]   sdramAddr,
	input  logic [sdramGeomPkg::DQM_W-1:0]  dqm,
	inout  wire [sdramGeomPkg::DATA_W-1:0]  dq
);
	import sdramGeomPkg::*;
	import sdramCmdPkg::*;

	data_t           mem [addr_t];             // Sparse storage
	logic [ROW_W-1:0] openRow [4];              // Row per bank
	logic [BANK_W-1:0] curBank;
	logic [COL_W-1:0] col;                      // Burst column, wraps in page
	logic             reading;
	logic             writing;
	logic             pipeVld [CAS_LATENCY];    // Read beats in flight
	addr_t            pipeAddr [CAS_LATENCY];
	logic             driveEn;
	data_t            driveVal;

	assign dq = driveEn ? driveVal : 'z;

	always @(posedge CLK)
	begin
		sdramCmd_t c;
		logic      beat;
		addr_t     a;
		c    = sdramCmd_t'({csN, rasN, casN, weN});
		beat = 1'b0;
		case (c)
		ACTIVE:
			openRow[bank] = sdramAddr[ROW_W-1:0];
		READ, WRITE:
		begin
			curBank = bank;
			col     = sdramAddr[COL_W-1:0];
			reading = (c == READ);
			writing = (c == WRITE);
		end
		BURST_STOP, PRECHARGE:
		begin
			reading = 1'b0;                         // Burst ends here
			writing = 1'b0;
		end
		default: ;
		endcase
		a = {curBank, openRow[curBank], col};
		if (writing && dqm == '0)
		begin
			mem[a] = dq;                            // Data rides with command
			beat   = 1'b1;
		end
		// Shift read pipe, CAS_LATENCY-1 stages to the pins
		for (int i = CAS_LATENCY - 1; i > 0; i--)
		begin
			pipeVld[i]  = pipeVld[i-1];
			pipeAddr[i] = pipeAddr[i-1];
		end
		pipeVld[0]  = reading;
		pipeAddr[0] = a;
		if (reading)
			beat = 1'b1;
		if (beat)
			col = col + 1'b1;
		driveEn  <= pipeVld[CAS_LATENCY-1];
		driveVal <= mem.exists(pipeAddr[CAS_LATENCY-1]) ? mem[pipeAddr[CAS_LATENCY-1]] : 'x;
	end

	initial
	begin
		reading = 1'b0;
		writing = 1'b0;
		driveEn = 1'b0;
		curBank = '0;
		col     = '0;
		for (int i = 0; i < CAS_LATENCY; i++)
			pipeVld[i] = 1'b0;
		for (int i = 0; i < 4; i++)
			openRow[i] = '0;
	end

endmodule

// ==== sdramCtrl_asserts.sv ====
`timescale 1ns/1ps
module sdramCtrl_asserts (
	input logic                   CLK,
	input logic                   RESET_N,
	input sdramCmdPkg::seqState_t state,
	input sdramCmdPkg::sdramCmd_t cmd,
	input logic                   burstDone,
	input logic                   dataOe,
	input logic                   readWindow
);
	import sdramCmdPkg::*;

	// REFRESH on pins was decided in IDLE or power-up
	refreshFromIdle: assert property (@(posedge CLK) disable iff (!RESET_N)
		(cmd == REFRESH) |-> ($past(state) inside {IDLE, INIT_REF}))
		else $error("REFRESH decided outside idle or init");

	donePulse: assert property (@(posedge CLK) disable iff (!RESET_N)
		burstDone |=> !burstDone)
		else $error("burstDone longer than one cycle");

	// Never drive DQ while reading
	noBusFight: assert property (@(posedge CLK) disable iff (!RESET_N)
		!(dataOe && readWindow))
		else $error("dataOe and readWindow both high");

endmodule

bind burstSequencer sdramCtrl_asserts u_asserts (
	.CLK(CLK), .RESET_N(RESET_N), .state(state), .cmd(cmd),
	.burstDone(burstDone), .dataOe(dataOe), .readWindow(readWindow)
);

// ==== tb_sdramCtrl.sv ====
`timescale 1ns/1ps
module tb_sdramCtrl;
	import sdramGeomPkg::*;
	import sdramCmdPkg::*;

	localparam int CL      = 3;
	localparam int REF_PER = 200;
	localparam int DEPTH   = 64;
	localparam int LIMIT   = 5000;      // Cycles per wait
	localparam int NROWS   = 3;
	localparam int SETTLE  = 12;        // Covers a refresh ahead of a held start

	logic CLK, RESET_N;
	data_t wrData, rdData;
	logic wrPush, wrFull, wrLoad, rdPop, rdEmpty, rdLoad;
	addr_t wrBase, wrMax, rdBase, rdMax;
	len_t wrLength, rdLength;
	logic [SA_W-1:0] sdramAddr;
	logic [BANK_W-1:0] bank;
	logic csN, cke, rasN, casN, weN;
	logic [DQM_W-1:0] dqm;
	wire [DATA_W-1:0] dq;

	// Stimulus table, expected addresses worked out from the wrap rule
	addr_t rowBase [NROWS];
	addr_t rowMax [NROWS];
	len_t  rowLen [NROWS];
	int    rowBursts [NROWS];          // Bursts per wrap cycle
	addr_t rowExp [NROWS][4];

	data_t refMem [addr_t];            // Expected memory contents
	addr_t wrSeen [$];                 // Burst addresses from the pins
	addr_t rdSeen [$];
	logic  opSeen [$];                 // 1 for WRITE
	logic  inBurst;
	int    refreshCount;
	logic [ROW_W-1:0] actRow;
	logic [BANK_W-1:0] actBank;
	logic [15:0] lfsr;

	sdramCtrl #(.CAS_LATENCY(CL), .INIT_WAIT(20), .REFRESH_PERIOD(REF_PER),
		.FIFO_DEPTH(DEPTH)) u_dut (.*);

	sdramModel #(.CAS_LATENCY(CL)) u_mem (.CLK(CLK), .csN(csN), .rasN(rasN),
		.casN(casN), .weN(weN), .bank(bank), .sdramAddr(sdramAddr), .dqm(dqm), .dq(dq));

	initial
	begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// ========================================
	// Reporting and compare tasks
	// ========================================
	task automatic reportFailure();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic timeoutFail(string what);
		$display("Timed out waiting for %s", what);
		reportFailure();
	endtask

	task automatic checkData(string name, data_t got, data_t exp);
		if (got !== exp)
		begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			reportFailure();
		end
	endtask

	task automatic checkAddr(string name, addr_t got, addr_t exp);
		if (got !== exp)
		begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			reportFailure();
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp)
		begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			reportFailure();
		end
	endtask

	task automatic checkCmd(string name, sdramCmd_t got, sdramCmd_t exp);
		if (got !== exp)
		begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			reportFailure();
		end
	endtask

	// Galois LFSR, one step per bit
	function automatic logic [15:0] lfsrStep(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic nextWord(output data_t w);
		for (int i = 0; i < DATA_W; i++)
		begin
			lfsr = lfsrStep(lfsr);
			w[i] = lfsr[0];
		end
	endtask

	task automatic tick(int n = 1);
		repeat (n) @(posedge CLK);
		#2;                                 // Drive point
	endtask

	// Pin monitor, decodes bursts and refreshes
	always @(posedge CLK)
	begin
		sdramCmd_t c;
		addr_t     a;
		c = sdramCmd_t'({csN, rasN, casN, weN});
		if (RESET_N)
		begin
			a = {actBank, actRow, sdramAddr[COL_W-1:0]};
			case (c)
			ACTIVE:
			begin
				actRow  = sdramAddr[ROW_W-1:0];
				actBank = bank;
				inBurst = 1'b1;
			end
			WRITE:
			begin
				wrSeen.push_back(a);
				opSeen.push_back(1'b1);
			end
			READ:
			begin
				rdSeen.push_back(a);
				opSeen.push_back(1'b0);
			end
			PRECHARGE:
				inBurst = 1'b0;
			REFRESH:
			begin
				refreshCount++;
				if (inBurst)
				begin
					$display("REFRESH issued between ACTIVE and PRECHARGE");
					reportFailure();
				end
			end
			default: ;
			endcase
		end
	end

	// Let any burst in flight finish and its read data drain
	task automatic settleBursts();
		int n;
		n = 0;
		tick(SETTLE);
		while (inBurst)
		begin
			tick();
			n++;
			if (n > LIMIT)
				timeoutFail("burst to finish");
		end
		tick(CL + 8);
	endtask

	task automatic checkReadAddrs(int r);
		for (int i = 0; i < rdSeen.size(); i++)
			checkAddr("read burst address", rdSeen[i], rowExp[r][i % rowBursts[r]]);
	endtask

	task automatic pushWord(data_t w);
		int n;
		n = 0;
		while (wrFull)
		begin
			tick();
			n++;
			if (n > LIMIT)
				timeoutFail("write FIFO room");
		end
		wrData = w;
		wrPush = 1'b1;
		tick();
		wrPush = 1'b0;
	endtask

	task automatic setPorts(int r);
		wrBase   = rowBase[r];
		rdBase   = rowBase[r];
		wrMax    = rowMax[r];
		rdMax    = rowMax[r];
		wrLength = rowLen[r];
		rdLength = rowLen[r];
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial
	begin
		data_t w;
		addr_t a;
		int    n;
		int    words;
		int    refStart;
		lfsr = 16'd97;
		inBurst = 1'b0;
		refreshCount = 0;
		actRow = '0;
		actBank = '0;
		RESET_N = 1'b0;
		wrData = '0;
		wrPush = 1'b0;
		rdPop = 1'b0;
		wrLoad = 1'b1;
		rdLoad = 1'b1;
		wrBase = '0;
		wrMax = '0;
		rdBase = '0;
		rdMax = '0;
		wrLength = '0;
		rdLength = '0;

		rowBase[0] = 22'h000000;
		rowMax[0] = 22'h000040;
		rowLen[0] = 16;
		rowBursts[0] = 3;
		rowExp[0] = '{22'h000000, 22'h000010, 22'h000020, 22'h0};
		rowBase[1] = 22'h001000;
		rowMax[1] = 22'h001060;
		rowLen[1] = 32;
		rowBursts[1] = 2;
		rowExp[1] = '{22'h001000, 22'h001020, 22'h0, 22'h0};
		rowBase[2] = 22'h200100;
		rowMax[2] = 22'h200128;
		rowLen[2] = 8;
		rowBursts[2] = 4;
		rowExp[2] = '{22'h200100, 22'h200108, 22'h200110, 22'h200118};

		// Reset state
		tick(4);
		checkCmd("cmd in reset", sdramCmd_t'({csN, rasN, casN, weN}), NOP);
		checkFlag("cke", cke, 1'b1);
		checkFlag("dqm all ones", &dqm, 1'b1);
		checkFlag("rdEmpty", rdEmpty, 1'b1);
		checkFlag("wrFull", wrFull, 1'b0);
		tick(4);
		RESET_N = 1'b1;
		tick();
		checkCmd("cmd after reset", sdramCmd_t'({csN, rasN, casN, weN}), NOP);
		checkFlag("dqm after reset", &dqm, 1'b1);

		for (int r = 0; r < NROWS; r++)
		begin
			wrLoad = 1'b1;
			rdLoad = 1'b1;
			settleBursts();
			if (r > 0)
				checkReadAddrs(r - 1);
			rdSeen.delete();
			wrSeen.delete();
			setPorts(r);
			tick(2);
			wrLoad = 1'b0;
			tick();

			// Fill one wrap cycle of bursts
			words = rowBursts[r] * rowLen[r];
			for (int k = 0; k < words; k++)
			begin
				nextWord(w);
				refMem[rowExp[r][k / rowLen[r]] + k % rowLen[r]] = w;
				pushWord(w);
			end
			n = 0;
			while (wrSeen.size() < rowBursts[r] || inBurst)
			begin
				tick();
				n++;
				if (n > LIMIT)
					timeoutFail("write bursts");
			end
			for (int i = 0; i < rowBursts[r]; i++)
				checkAddr("write burst address", wrSeen[i], rowExp[r][i]);

			// Read back in order
			rdLoad = 1'b0;
			for (int k = 0; k < words; k++)
			begin
				n = 0;
				while (rdEmpty)
				begin
					tick();
					n++;
					if (n > LIMIT)
						timeoutFail("read data");
				end
				a = rowExp[r][k / rowLen[r]] + k % rowLen[r];
				checkData("rdData", rdData, refMem[a]);
				rdPop = 1'b1;
				tick();
				rdPop = 1'b0;
			end
		end

		// Write priority, both ports made eligible together
		wrLoad = 1'b1;
		rdLoad = 1'b1;
		settleBursts();
		checkReadAddrs(NROWS - 1);
		setPorts(0);
		wrLength = '0;                      // Holds the write side back
		tick(2);
		wrLoad = 1'b0;
		tick();
		for (int k = 0; k < 16; k++)
		begin
			nextWord(w);
			pushWord(w);
		end
		tick(2);
		opSeen.delete();
		wrLength = 16;
		rdLoad = 1'b0;
		n = 0;
		while (opSeen.size() == 0)
		begin
			tick();
			n++;
			if (n > LIMIT)
				timeoutFail("first burst after idle");
		end
		checkFlag("first burst is WRITE", opSeen[0], 1'b1);

		// Load clears the read FIFO and reloads rdBase
		n = 0;
		while (rdEmpty)
		begin
			tick();
			n++;
			if (n > LIMIT)
				timeoutFail("read FIFO to fill");
		end
		rdLoad = 1'b1;
		tick();
		checkFlag("rdEmpty after rdLoad", rdEmpty, 1'b1);
		settleBursts();
		rdSeen.delete();
		rdLoad = 1'b0;
		n = 0;
		while (rdSeen.size() == 0)
		begin
			tick();
			n++;
			if (n > LIMIT)
				timeoutFail("read burst after load");
		end
		checkAddr("read address after load", rdSeen[0], rowBase[0]);

		// Long idle stretch, refresh keeps running
		rdLoad = 1'b1;
		settleBursts();
		refStart = refreshCount;
		tick(3 * REF_PER);
		checkFlag("refresh repeated in idle", (refreshCount - refStart) >= 2, 1'b1);

		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== sdramCtrl.f ====
sdramGeomPkg.sv
sdramCmdPkg.sv
syncFifo.sv
portArbiter.sv
burstSequencer.sv
sdramDataPath.sv
sdramCtrl.sv
sdramModel.sv
sdramCtrl_asserts.sv
tb_sdramCtrl.sv
